/* core.f */
+incdir+include
design/core_pkg.sv
design/fetch.sv
design/decoder.sv
design/regf.sv
design/stage_reg.sv
design/execute.sv
design/mem_access.sv
design/core.sv
verification/core_asserts.sv
verification/core_tb.sv

/* verification/core_tb.sv */
`timescale 1ns/100ps
`include "core_params.svh"

module core_tb;

   localparam int               rom_words   = 64;
   localparam int               dmem_words  = 256;
   localparam int               run_limit   = 1000;
   localparam logic [`XLEN-1:0] final_store = 32'h0000_013C;
   localparam logic [6:0]       op_imm      = 7'h13;
   localparam logic [6:0]       op_load     = 7'h03;

   logic             clk;
   logic             rstn;
   logic [`XLEN-1:0] rom_addr;
   logic [`XLEN-1:0] rom_data;
   logic [`XLEN-1:0] dmem_addr;
   logic [`XLEN-1:0] dmem_wdata;
   logic             dmem_we;
   logic             dmem_re;
   logic [`XLEN-1:0] dmem_rdata;

   logic [`XLEN-1:0] rom  [rom_words];
   logic [`XLEN-1:0] dmem [dmem_words];
   int               rom_len;

   core dut0 (
      .clk        (clk),
      .rstn       (rstn),
      .rom_addr   (rom_addr),
      .rom_data   (rom_data),
      .dmem_addr  (dmem_addr),
      .dmem_wdata (dmem_wdata),
      .dmem_we    (dmem_we),
      .dmem_re    (dmem_re),
      .dmem_rdata (dmem_rdata)
   );

   bind core core_asserts #(
      .load_use_pairs (3),
      .taken_branches (3)
   ) asserts0 (
      .clk            (clk),
      .rstn           (rstn),
      .rom_addr       (rom_addr),
      .rom_data       (rom_data),
      .dmem_addr      (dmem_addr),
      .dmem_wdata     (dmem_wdata),
      .dmem_we        (dmem_we),
      .dmem_re        (dmem_re),
      .load_use_stall (load_use_stall),
      .flush          (flush)
   );

   ////////////////////////////////////////////////////////////////////////////
   // instruction encoders
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] imm_form(input logic [31:0] opc, f3, rd, rs1, imm);
      return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
   endfunction

   function automatic logic [31:0] reg_form(input logic [31:0] f7, f3, rd, rs1, rs2);
      return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
   endfunction

   function automatic logic [31:0] store_form(input logic [31:0] rs2, rs1, imm);
      return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
   endfunction

   function automatic logic [31:0] branch_form(input logic [31:0] f3, rs1, rs2, off);
      return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
   endfunction

   function automatic logic [31:0] jump_form(input logic [31:0] rd, off);
      return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
   endfunction

   function automatic logic [31:0] upper_form(input logic [31:0] rd, imm);
      return {imm[19:0], rd[4:0], 7'h37};
   endfunction

   task automatic emit(input logic [31:0] word);
      rom[rom_len] = word;
      rom_len++;
   endtask

   // stores must write 0x100, 0x104 ... 0x13c, each holding its own address
   task automatic load_program();
      rom_len = 0;
      for (int i = 0; i < rom_words; i++) begin
         rom[i] = `NOP_INSTR;
      end
      // x20 holds the poison value
      emit(upper_form(20, 'hBAD00));
      // one-step and two-step forwarding chains
      emit(imm_form(op_imm, 0, 1, 0, 'h100));
      emit(store_form(1, 1, 'h0));
      emit(imm_form(op_imm, 0, 2, 1, 4));
      emit(store_form(2, 1, 'h4));
      emit(imm_form(op_imm, 0, 3, 2, 4));
      emit(reg_form(0, 4, 4, 3, 0));
      emit(store_form(4, 1, 'h8));
      emit(imm_form(op_imm, 0, 5, 0, 'hC));
      emit(reg_form(0, 6, 6, 1, 5));
      emit(store_form(6, 1, 'hC));
      // load-use pairs
      emit(imm_form(op_load, 2, 7, 0, 'h104));
      emit(reg_form(0, 0, 8, 7, 5));
      emit(store_form(8, 1, 'h10));
      emit(imm_form(op_load, 2, 9, 0, 'h120));
      emit(reg_form('h20, 0, 10, 9, 5));
      emit(store_form(10, 1, 'h14));
      emit(imm_form(op_load, 2, 11, 0, 'h118));
      emit(store_form(11, 1, 'h18));
      // taken beq skips two poison stores
      emit(imm_form(op_imm, 0, 12, 1, 'h1C));
      emit(branch_form(0, 12, 12, 12));
      emit(store_form(20, 0, 'h80));
      emit(store_form(20, 0, 'h84));
      emit(store_form(12, 1, 'h1C));
      // beq falls through, bne is taken
      emit(imm_form(op_imm, 0, 13, 12, 4));
      emit(branch_form(0, 13, 12, 12));
      emit(store_form(13, 1, 'h20));
      emit(branch_form(1, 13, 1, 12));
      emit(store_form(20, 0, 'h88));
      emit(store_form(20, 0, 'h8C));
      emit(imm_form(op_imm, 0, 14, 13, 4));
      emit(store_form(14, 1, 'h24));
      // jal link value feeds the next store
      emit(jump_form(15, 12));
      emit(store_form(20, 0, 'h90));
      emit(store_form(20, 0, 'h94));
      emit(imm_form(op_imm, 0, 16, 15, 'hA4));
      emit(store_form(16, 1, 'h28));
      // slt, and, lui
      emit(reg_form(0, 2, 17, 5, 1));
      emit(imm_form(op_imm, 0, 21, 17, 'h12B));
      emit(store_form(21, 1, 'h2C));
      emit(reg_form(0, 7, 18, 1, 13));
      emit(imm_form(op_imm, 0, 22, 18, 'h30));
      emit(store_form(22, 1, 'h30));
      emit(upper_form(23, 1));
      emit(imm_form(op_imm, 0, 24, 23, -'h7CC));
      emit(imm_form(op_imm, 0, 24, 24, -'h700));
      emit(store_form(24, 1, 'h34));
      emit(imm_form(op_imm, 0, 25, 24, 4));
      emit(imm_form(op_imm, 0, 26, 25, 4));
      emit(store_form(25, 1, 'h38));
      emit(store_form(26, 1, 'h3C));
      // park here
      emit(jump_form(0, 0));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // memories and clock
   ////////////////////////////////////////////////////////////////////////////

   assign rom_data   = rom[rom_addr[7:2]];
   assign dmem_rdata = dmem[dmem_addr[9:2]];

   always @(posedge clk) begin
      if (dmem_we) begin
         dmem[dmem_addr[9:2]] <= dmem_wdata;
      end
   end

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // first assertion failure ends the run
   always @(negedge clk) begin
      if (dut0.asserts0.fail_count != 0) begin
         $display("Test FAILED");
         $fatal(1, "a core check failed");
      end
   end

   initial begin
      int   cycles;
      logic done;
      rstn   = 1'b1;
      cycles = 0;
      done   = 1'b0;
      load_program();
      // every word holds its own byte address
      for (int i = 0; i < dmem_words; i++) begin
         dmem[i] = i * 4;
      end
      repeat (16) @(negedge clk);
      rstn = 1'b0;

      while (!done && cycles < run_limit) begin
         @(negedge clk);
         cycles++;
         done = dmem_we && dmem_addr == final_store;
      end

      if (!done) begin
         $display("program did not reach its final store");
         $display("Test FAILED");
         $fatal(1, "no final store after %0d cycles", cycles);
      end else begin
         // checks on the last store sample at the next edge
         repeat (2) @(negedge clk);
         if (dut0.asserts0.fail_count == 0) begin
            $display("Test OK");
            $finish;
         end else begin
            $display("Test FAILED");
            $fatal(1, "core checks failed");
         end
      end
   end

endmodule

/* verification/core_asserts.sv */
`timescale 1ns/100ps
`include "core_params.svh"

module core_asserts #(
   parameter int load_use_pairs = 0,
   parameter int taken_branches = 0
) (
   input logic             clk,
   input logic             rstn,
   input logic [`XLEN-1:0] rom_addr,
   input logic [`XLEN-1:0] rom_data,
   input logic [`XLEN-1:0] dmem_addr,
   input logic [`XLEN-1:0] dmem_wdata,
   input logic             dmem_we,
   input logic             dmem_re,
   input logic             load_use_stall,
   input logic             flush
);

   localparam logic [`XLEN-1:0] first_store = 32'h0000_0100;
   localparam logic [`XLEN-1:0] last_store  = 32'h0000_013C;
   localparam logic [`XLEN-1:0] poison      = 32'hBAD0_0000;

   int               fail_count = 0;
   logic             clocked = 1'b0;
   logic [`XLEN-1:0] next_store;
   int               stall_cycles;
   int               flush_cycles;
   logic [`XLEN-1:0] fetch_target;
   logic [`XLEN-1:0] fd_target;
   logic [`XLEN-1:0] ex_target;

   // expected store address and hazard event counts
   always_ff @(posedge clk) begin
      clocked <= 1'b1;
      if (rstn) begin
         next_store   <= first_store;
         stall_cycles <= 0;
         flush_cycles <= 0;
      end else begin
         if (dmem_we) begin
            next_store <= next_store + `XLEN'd4;
         end
         if (load_use_stall) begin
            stall_cycles <= stall_cycles + 1;
         end
         if (flush) begin
            flush_cycles <= flush_cycles + 1;
         end
      end
   end

   // target of a beq, bne or jal as it is fetched
   always_comb begin
      case (rom_data[6:0])
         7'h63: begin
            fetch_target = rom_addr + {{20{rom_data[31]}}, rom_data[7], rom_data[30:25],
                                       rom_data[11:8], 1'b0};
         end
         7'h6f: begin
            fetch_target = rom_addr + {{12{rom_data[31]}}, rom_data[19:12], rom_data[20],
                                       rom_data[30:21], 1'b0};
         end
         default: fetch_target = '0;
      endcase
   end

   // follow that target down to execute, a stall keeps it in decode
   always_ff @(posedge clk) begin
      if (!load_use_stall) begin
         fd_target <= fetch_target;
         ex_target <= fd_target;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // data port
   ////////////////////////////////////////////////////////////////////////////

   store_value: assert property (@(posedge clk) disable iff (rstn)
      dmem_we |-> dmem_wdata == dmem_addr)
      else begin
         $error("FAIL %0t: store of %h to address %h", $time,
                $sampled(dmem_wdata), $sampled(dmem_addr));
         fail_count++;
      end

   // wrong-path stores carry this value
   no_poison: assert property (@(posedge clk) disable iff (rstn)
      dmem_we |-> dmem_wdata != poison)
      else begin
         $error("FAIL %0t: flushed store reached the data port", $time);
         fail_count++;
      end

   store_order: assert property (@(posedge clk) disable iff (rstn)
      dmem_we |-> dmem_addr == next_store)
      else begin
         $error("FAIL %0t: store to %h, expected %h", $time,
                $sampled(dmem_addr), $sampled(next_store));
         fail_count++;
      end

   ////////////////////////////////////////////////////////////////////////////
   // stall and flush
   ////////////////////////////////////////////////////////////////////////////

   single_stall: assert property (@(posedge clk) disable iff (rstn)
      load_use_stall |=> !load_use_stall)
      else begin
         $error("FAIL %0t: load-use stall lasted more than one cycle", $time);
         fail_count++;
      end

   stall_holds_fetch: assert property (@(posedge clk) disable iff (rstn)
      load_use_stall && !flush |=> $stable(rom_addr))
      else begin
         $error("FAIL %0t: fetch moved on during a stall", $time);
         fail_count++;
      end

   redirect: assert property (@(posedge clk) disable iff (rstn)
      flush |=> rom_addr == $past(ex_target))
      else begin
         $error("FAIL %0t: rom_addr %h after a taken branch", $time, $sampled(rom_addr));
         fail_count++;
      end

   // one stall per load-use pair, one flush per taken branch
   hazard_counts: assert property (@(posedge clk) disable iff (rstn)
      dmem_we && dmem_addr == last_store |->
         stall_cycles == load_use_pairs && flush_cycles == taken_branches)
      else begin
         $error("FAIL %0t: %0d stall and %0d flush cycles", $time,
                $sampled(stall_cycles), $sampled(flush_cycles));
         fail_count++;
      end

   ////////////////////////////////////////////////////////////////////////////
   // reset
   ////////////////////////////////////////////////////////////////////////////

   quiet_in_reset: assert property (@(posedge clk)
      clocked && rstn |-> !dmem_we && !dmem_re)
      else begin
         $error("FAIL %0t: data strobe active during reset", $time);
         fail_count++;
      end

   reset_vector: assert property (@(posedge clk)
      $fell(rstn) |-> rom_addr == `RESET_PC)
      else begin
         $error("FAIL %0t: first fetch from %h", $time, $sampled(rom_addr));
         fail_count++;
      end

endmodule

/* design/core.sv */
`timescale 1ns/100ps
`include "core_params.svh"

module core import core_pkg::*; (
   input  logic             clk,
   input  logic             rstn,
   output logic [`XLEN-1:0] rom_addr,
   input  logic [`XLEN-1:0] rom_data,
   output logic [`XLEN-1:0] dmem_addr,
   output logic [`XLEN-1:0] dmem_wdata,
   output logic             dmem_we,
   output logic             dmem_re,
   input  logic [`XLEN-1:0] dmem_rdata
);

   fd_payload_t      fd_d, fd_q, fd_bubble;
   de_payload_t      de_d, de_q, de_bubble;
   em_payload_t      em_d, em_q, em_bubble;
   mw_payload_t      mw_d, mw_q, mw_bubble;

   reg_idx_t         rs1_idx;
   reg_idx_t         rs2_idx;
   logic [`XLEN-1:0] rs1_val;
   logic [`XLEN-1:0] rs2_val;

   logic             branch_taken;
   logic [`XLEN-1:0] branch_target;
   logic             load_use_stall;
   logic             flush;

   ////////////////////////////////////////////////////////////////////////////
   // hazard control
   ////////////////////////////////////////////////////////////////////////////

   // load in execute, its consumer in decode
   assign load_use_stall = de_q.valid && de_q.is_load && de_q.rd != '0 && de_d.valid &&
                           ((de_d.uses_rs1 && de_d.rs1 == de_q.rd) ||
                            (de_d.uses_rs2 && de_d.rs2 == de_q.rd));

   // already qualified by valid inside execute
   assign flush = branch_taken;

   // empty slots per boundary
   assign fd_bubble = '{pc: `RESET_PC, instr: `NOP_INSTR, valid: 1'b0};
   assign em_bubble = '0;
   assign mw_bubble = '0;

   always_comb begin
      de_bubble        = '0;
      de_bubble.opcode = opc_bubble;
      de_bubble.alu_op = alu_add;
   end

   ////////////////////////////////////////////////////////////////////////////
   // pipeline
   ////////////////////////////////////////////////////////////////////////////

   fetch fetch0 (
      .clk         (clk),
      .rstn        (rstn),
      .hold        (load_use_stall),
      .redirect    (flush),
      .redirect_pc (branch_target),
      .rom_addr    (rom_addr),
      .rom_data    (rom_data),
      .fd_out      (fd_d)
   );

   stage_reg #(.payload_t(fd_payload_t)) fd0 (
      .clk    (clk),
      .rstn   (rstn),
      .hold   (load_use_stall),
      .flush  (flush),
      .bubble (fd_bubble),
      .d      (fd_d),
      .q      (fd_q)
   );

   decoder decoder0 (
      .fd_in   (fd_q),
      .rs1_val (rs1_val),
      .rs2_val (rs2_val),
      .rs1     (rs1_idx),
      .rs2     (rs2_idx),
      .de_out  (de_d)
   );

   // write port fed directly from the write-back slot
   regf regf0 (
      .clk      (clk),
      .rstn     (rstn),
      .rs1      (rs1_idx),
      .rs2      (rs2_idx),
      .w_enable (mw_q.valid && mw_q.writes_rd),
      .w_addr   (mw_q.rd),
      .w_data   (mw_q.wb_data),
      .rs1_val  (rs1_val),
      .rs2_val  (rs2_val)
   );

   // a stall inserts a bubble behind the load
   stage_reg #(.payload_t(de_payload_t)) de0 (
      .clk    (clk),
      .rstn   (rstn),
      .hold   (1'b0),
      .flush  (flush || load_use_stall),
      .bubble (de_bubble),
      .d      (de_d),
      .q      (de_q)
   );

   execute execute0 (
      .de_in         (de_q),
      .fwd_em        (em_q),
      .fwd_mw        (mw_q),
      .em_out        (em_d),
      .branch_taken  (branch_taken),
      .branch_target (branch_target)
   );

   stage_reg #(.payload_t(em_payload_t)) em0 (
      .clk    (clk),
      .rstn   (rstn),
      .hold   (1'b0),
      .flush  (1'b0),
      .bubble (em_bubble),
      .d      (em_d),
      .q      (em_q)
   );

   mem_access mem_access0 (
      .em_in      (em_q),
      .dmem_addr  (dmem_addr),
      .dmem_wdata (dmem_wdata),
      .dmem_we    (dmem_we),
      .dmem_re    (dmem_re),
      .dmem_rdata (dmem_rdata),
      .mw_out     (mw_d)
   );

   stage_reg #(.payload_t(mw_payload_t)) mw0 (
      .clk    (clk),
      .rstn   (rstn),
      .hold   (1'b0),
      .flush  (1'b0),
      .bubble (mw_bubble),
      .d      (mw_d),
      .q      (mw_q)
   );

endmodule

/* design/mem_access.sv */
`timescale 1ns/100ps
`include "core_params.svh"

module mem_access import core_pkg::*; (
   input  em_payload_t      em_in,
   output logic [`XLEN-1:0] dmem_addr,
   output logic [`XLEN-1:0] dmem_wdata,
   output logic             dmem_we,
   output logic             dmem_re,
   input  logic [`XLEN-1:0] dmem_rdata,
   output mw_payload_t      mw_out
);

   logic [`XLEN-1:0] wb_sel;

   // address comes straight out of the alu
   assign dmem_addr  = em_in.result;
   assign dmem_wdata = em_in.store_data;

   // strobes only for real loads and stores
   assign dmem_we = em_in.valid && em_in.is_store;
   assign dmem_re = em_in.valid && em_in.is_load;

   // read data arrives in the same cycle as the strobe
   assign wb_sel = em_in.is_load ? dmem_rdata : em_in.result;

   assign mw_out = '{
      rd:        em_in.rd,
      writes_rd: em_in.writes_rd,
      wb_data:   wb_sel,
      valid:     em_in.valid
   };

endmodule

/* design/execute.sv */
`timescale 1ns/100ps
`include "core_params.svh"

module execute import core_pkg::*; (
   input  de_payload_t      de_in,
   input  em_payload_t      fwd_em,
   input  mw_payload_t      fwd_mw,
   output em_payload_t      em_out,
   output logic             branch_taken,
   output logic [`XLEN-1:0] branch_target
);

   logic [`XLEN-1:0] src1;
   logic [`XLEN-1:0] src2;
   logic [`XLEN-1:0] op_b;
   logic [`XLEN-1:0] alu_res;
   logic [`XLEN-1:0] pc_plus4;
   logic             equal;

   // one-step source first, loads are not ready there yet
   function automatic logic [`XLEN-1:0] pick_operand(
      input reg_idx_t         idx,
      input logic [`XLEN-1:0] reg_val,
      input em_payload_t      em,
      input mw_payload_t      mw
   );
      if (idx != '0 && em.valid && em.writes_rd && !em.is_load && em.rd == idx) begin
         return em.result;
      end
      if (idx != '0 && mw.valid && mw.writes_rd && mw.rd == idx) begin
         return mw.wb_data;
      end
      return reg_val;
   endfunction

   assign src1 = pick_operand(de_in.rs1, de_in.rs1_val, fwd_em, fwd_mw);
   assign src2 = pick_operand(de_in.rs2, de_in.rs2_val, fwd_em, fwd_mw);

   // register operand only for r-type, everything else takes the immediate
   assign op_b = (de_in.opcode == opc_op_reg) ? src2 : de_in.imm;

   always_comb begin
      case (de_in.alu_op)
         alu_add:    alu_res = src1 + op_b;
         alu_sub:    alu_res = src1 - op_b;
         alu_and:    alu_res = src1 & op_b;
         alu_or:     alu_res = src1 | op_b;
         alu_xor:    alu_res = src1 ^ op_b;
         alu_slt:    alu_res = {{(`XLEN-1){1'b0}}, $signed(src1) < $signed(op_b)};
         alu_pass_b: alu_res = op_b;
         default:    alu_res = src1 + op_b;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // branch resolution
   ////////////////////////////////////////////////////////////////////////////

   assign pc_plus4      = de_in.pc + `XLEN'd4;
   assign equal         = (src1 == src2);
   assign branch_target = de_in.pc + de_in.imm;
   assign branch_taken  = de_in.valid &&
                          ((de_in.opcode == opc_branch && (equal ^ de_in.is_branch_ne)) ||
                           de_in.opcode == opc_jal);

   // jal links pc + 4
   assign em_out = '{
      rd:         de_in.rd,
      writes_rd:  de_in.writes_rd,
      is_load:    de_in.is_load,
      is_store:   de_in.is_store,
      result:     (de_in.opcode == opc_jal) ? pc_plus4 : alu_res,
      store_data: src2,
      valid:      de_in.valid
   };

endmodule

/* design/stage_reg.sv */
`timescale 1ns/100ps

module stage_reg #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rstn,
   input  logic     hold,
   input  logic     flush,
   input  payload_t bubble,
   input  payload_t d,
   output payload_t q
);

   ////////////////////////////////////////////////////////////////////////////
   // boundary register
   ////////////////////////////////////////////////////////////////////////////

   // flush beats hold, so a redirect during a stall still kills the slot
   always_ff @(posedge clk) begin
      if (rstn || flush) begin
         q <= bubble;
      end else if (!hold) begin
         q <= d;
      end
   end

endmodule

/* design/regf.sv */
`timescale 1ns/100ps
`include "core_params.svh"

module regf import core_pkg::*; (
   input  logic             clk,
   input  logic             rstn,
   input  reg_idx_t         rs1,
   input  reg_idx_t         rs2,
   input  logic             w_enable,
   input  reg_idx_t         w_addr,
   input  logic [`XLEN-1:0] w_data,
   output logic [`XLEN-1:0] rs1_val,
   output logic [`XLEN-1:0] rs2_val
);

   logic [`XLEN-1:0] regs [`NREGS];

   always_ff @(posedge clk) begin
      if (rstn) begin
         for (int i = 0; i < `NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (w_enable && w_addr != '0) begin
         regs[w_addr] <= w_data;
      end
   end

   // x0 reads zero, a same-cycle write is passed straight through
   assign rs1_val = (rs1 == '0) ? '0 :
                    (w_enable && w_addr == rs1) ? w_data : regs[rs1];
   assign rs2_val = (rs2 == '0) ? '0 :
                    (w_enable && w_addr == rs2) ? w_data : regs[rs2];

endmodule

/* design/decoder.sv */
`timescale 1ns/100ps
`include "core_params.svh"

module decoder import core_pkg::*; (
   input  fd_payload_t      fd_in,
   input  logic [`XLEN-1:0] rs1_val,
   input  logic [`XLEN-1:0] rs2_val,
   output reg_idx_t         rs1,
   output reg_idx_t         rs2,
   output de_payload_t      de_out
);

   logic [`XLEN-1:0] instr;
   logic [6:0]       opc;
   logic [2:0]       funct3;
   logic [6:0]       funct7;
   logic [`XLEN-1:0] imm_i;
   logic [`XLEN-1:0] imm_s;
   logic [`XLEN-1:0] imm_b;
   logic [`XLEN-1:0] imm_u;
   logic [`XLEN-1:0] imm_j;
   logic             supported;

   assign instr  = fd_in.instr;
   assign opc    = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   // register file is read with the raw fields
   assign rs1 = instr[19:15];
   assign rs2 = instr[24:20];

   // immediate formats, all sign extended from bit 31
   assign imm_i = {{20{instr[31]}}, instr[31:20]};
   assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   assign imm_u = {instr[31:12], 12'h000};
   assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

   always_comb begin
      supported      = 1'b0;
      de_out         = '0;
      de_out.pc      = fd_in.pc;
      de_out.rd      = instr[11:7];
      de_out.rs1     = rs1;
      de_out.rs2     = rs2;
      de_out.rs1_val = rs1_val;
      de_out.rs2_val = rs2_val;
      de_out.opcode  = opc_bubble;
      de_out.alu_op  = alu_add;

      case (opc)
         7'b0010011: begin
            // only addi
            supported          = (funct3 == 3'b000);
            de_out.opcode      = opc_op_imm;
            de_out.imm         = imm_i;
            de_out.uses_rs1    = 1'b1;
            de_out.writes_rd   = 1'b1;
         end
         7'b0110011: begin
            supported          = 1'b1;
            de_out.opcode      = opc_op_reg;
            de_out.uses_rs1    = 1'b1;
            de_out.uses_rs2    = 1'b1;
            de_out.writes_rd   = 1'b1;
            case ({funct7, funct3})
               {7'h00, 3'b000}: de_out.alu_op = alu_add;
               {7'h20, 3'b000}: de_out.alu_op = alu_sub;
               {7'h00, 3'b111}: de_out.alu_op = alu_and;
               {7'h00, 3'b110}: de_out.alu_op = alu_or;
               {7'h00, 3'b100}: de_out.alu_op = alu_xor;
               {7'h00, 3'b010}: de_out.alu_op = alu_slt;
               default:         supported = 1'b0;
            endcase
         end
         7'b0110111: begin
            supported          = 1'b1;
            de_out.opcode      = opc_lui;
            de_out.alu_op      = alu_pass_b;
            de_out.imm         = imm_u;
            de_out.writes_rd   = 1'b1;
         end
         7'b0000011: begin
            // word loads only
            supported          = (funct3 == 3'b010);
            de_out.opcode      = opc_load;
            de_out.imm         = imm_i;
            de_out.uses_rs1    = 1'b1;
            de_out.writes_rd   = 1'b1;
            de_out.is_load     = 1'b1;
         end
         7'b0100011: begin
            supported          = (funct3 == 3'b010);
            de_out.opcode      = opc_store;
            de_out.imm         = imm_s;
            de_out.uses_rs1    = 1'b1;
            de_out.uses_rs2    = 1'b1;
            de_out.is_store    = 1'b1;
         end
         7'b1100011: begin
            // beq and bne
            supported          = (funct3 == 3'b000) || (funct3 == 3'b001);
            de_out.opcode      = opc_branch;
            de_out.imm         = imm_b;
            de_out.uses_rs1    = 1'b1;
            de_out.uses_rs2    = 1'b1;
            de_out.is_branch_ne = funct3[0];
         end
         7'b1101111: begin
            supported          = 1'b1;
            de_out.opcode      = opc_jal;
            de_out.imm         = imm_j;
            de_out.writes_rd   = 1'b1;
         end
         default: supported = 1'b0;
      endcase

      // anything else turns into a bubble
      if (!supported) begin
         de_out.opcode       = opc_bubble;
         de_out.alu_op       = alu_add;
         de_out.uses_rs1     = 1'b0;
         de_out.uses_rs2     = 1'b0;
         de_out.writes_rd    = 1'b0;
         de_out.is_load      = 1'b0;
         de_out.is_store     = 1'b0;
         de_out.is_branch_ne = 1'b0;
      end
      de_out.valid = fd_in.valid && supported;
   end

endmodule

/* design/fetch.sv */
`timescale 1ns/100ps
`include "core_params.svh"

module fetch import core_pkg::*; (
   input  logic             clk,
   input  logic             rstn,
   input  logic             hold,
   input  logic             redirect,
   input  logic [`XLEN-1:0] redirect_pc,
   output logic [`XLEN-1:0] rom_addr,
   input  logic [`XLEN-1:0] rom_data,
   output fd_payload_t      fd_out
);

   logic [`XLEN-1:0] pc;
   logic [`XLEN-1:0] pc_next;

   // taken branch wins over a load-use hold
   always_comb begin
      if (redirect) begin
         pc_next = redirect_pc;
      end else if (hold) begin
         pc_next = pc;
      end else begin
         pc_next = pc + `XLEN'd4;
      end
   end

   always_ff @(posedge clk) begin
      if (rstn) begin
         pc <= `RESET_PC;
      end else begin
         pc <= pc_next;
      end
   end

   // rom answers within the cycle
   assign rom_addr = pc;
   assign fd_out   = '{pc: pc, instr: rom_data, valid: 1'b1};

endmodule

/* design/core_pkg.sv */
`include "core_params.svh"

package core_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // basic types
   ////////////////////////////////////////////////////////////////////////////

   typedef logic [$clog2(`NREGS)-1:0] reg_idx_t;

   // instruction classes the decoder knows about
   typedef enum logic [2:0] {
      opc_op_imm,
      opc_op_reg,
      opc_lui,
      opc_load,
      opc_store,
      opc_branch,
      opc_jal,
      opc_bubble
   } opcode_e;

   typedef enum logic [2:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_slt,
      alu_pass_b
   } alu_op_e;

   ////////////////////////////////////////////////////////////////////////////
   // stage payloads
   ////////////////////////////////////////////////////////////////////////////

   // fetch -> decode
   typedef struct packed {
      logic [`XLEN-1:0] pc;
      logic [`XLEN-1:0] instr;
      logic             valid;
   } fd_payload_t;

   // decode -> execute, register values as read in decode
   typedef struct packed {
      logic [`XLEN-1:0] pc;
      reg_idx_t         rd;
      reg_idx_t         rs1;
      reg_idx_t         rs2;
      logic [`XLEN-1:0] imm;
      opcode_e          opcode;
      alu_op_e          alu_op;
      logic             uses_rs1;
      logic             uses_rs2;
      logic             writes_rd;
      logic             is_load;
      logic             is_store;
      logic             is_branch_ne;
      logic [`XLEN-1:0] rs1_val;
      logic [`XLEN-1:0] rs2_val;
      logic             valid;
   } de_payload_t;

   // execute -> memory, result doubles as the memory address
   typedef struct packed {
      reg_idx_t         rd;
      logic             writes_rd;
      logic             is_load;
      logic             is_store;
      logic [`XLEN-1:0] result;
      logic [`XLEN-1:0] store_data;
      logic             valid;
   } em_payload_t;

   // memory -> write-back
   typedef struct packed {
      reg_idx_t         rd;
      logic             writes_rd;
      logic [`XLEN-1:0] wb_data;
      logic             valid;
   } mw_payload_t;

endpackage

/* include/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// core sizing
////////////////////////////////////////////////////////////////////////////

// data and address width
`define XLEN 32

// integer register count, x0 included
`define NREGS 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif
